// ==== Makefile ====
TOP := bst_engine_tb
SHELL := /bin/bash
.SHELLFLAGS := -o pipefail -c

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "Simulation reported a failure"; exit 1; fi

obj_dir/V$(TOP): bst_engine.f $(wildcard design/*.sv design/*.svh bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		-f bst_engine.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -Wall -f bst_engine.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== bench/bst_engine_chk.sv ====
/*
 * Port protocol assertions, bound into the engine top level.
 */
`timescale 1ns/1ps

module bst_engine_chk (
    input logic              aclk,
    input logic              aresetn,
    input logic              cmd_req,
    input logic              cmd_ack,
    input logic              cpl_req,
    input logic              cpl_ack,
    input bst_pkg::bst_cpl_t cpl
);

    // Acknowledge only answers a pending request
    assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(cmd_ack) |-> $past(cmd_req))
        else $error("cmd_ack rose without cmd_req");

    // Completion held until the host answers
    assert property (@(posedge aclk) disable iff (!aresetn)
        (cpl_req && !cpl_ack) |=> (cpl_req && $stable(cpl)))
        else $error("cpl_req dropped or cpl changed before cpl_ack");

    assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(cpl_req) |-> !cpl_ack)
        else $error("cpl_req rose while cpl_ack was still high");

    assert property (@(posedge aclk) !aresetn |-> (!cmd_ack && !cpl_req))
        else $error("cmd_ack or cpl_req high during reset");

endmodule

bind bst_engine bst_engine_chk bst_engine_chk_i (
    .aclk, .aresetn, .cmd_req, .cmd_ack, .cpl_req, .cpl_ack, .cpl
);

// ==== bench/bst_engine_tb.sv ====
/*
 * Directed tests of the BST engine. Tokens and payloads are random with a
 * fixed seed; a token map is the reference model.
 */
`timescale 1ns/1ps

`include "bst_params.svh"

module bst_engine_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    // Commands per test, in run order; the tree holds 10 nodes before the fill
    localparam int CMD_COUNT = 1 + 21 + 2 + 3 + (2 * `BST_NODE_COUNT - 9) + 3;
    localparam int CYCLES_PER_CMD = 2 * `BST_NODE_COUNT + 20;

    logic              aclk;
    logic              aresetn;
    logic              cmd_req;
    logic              cmd_ack;
    bst_pkg::bst_req_t cmd;
    logic              cpl_req;
    logic              cpl_ack;
    bst_pkg::bst_cpl_t cpl;

    integer seed = 32'hbe47;
    int     pass_count;
    int     fail_count;
    logic [`BST_PAYLOAD_W-1:0] model [logic [`BST_TOKEN_W-1:0]];

    bst_engine bst_engine_i (
        .aclk, .aresetn, .cmd_req, .cmd_ack, .cmd, .cpl_req, .cpl_ack, .cpl
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    initial begin
        #((RESET_CYCLES + CMD_COUNT * CYCLES_PER_CMD) * CLK_PERIOD);
        $display("Watchdog expired: the tests did not finish in time");
        $display("TEST FAIL");
        $finish;
    end

    // ------------------------------------------------------------
    // Reference model and random data
    // ------------------------------------------------------------
    task automatic model_step(input logic [7:0] code, input logic [`BST_TOKEN_W-1:0] token,
                              input logic [`BST_PAYLOAD_W-1:0] payload,
                              output bst_pkg::bst_cpl_t exp);
        exp.payload = '0;
        exp.status  = 1'b1;
        if (code == bst_pkg::CMD_SEARCH && model.exists(token)) begin
            exp.payload = model[token];
            exp.status  = 1'b0;
        end else if (code == bst_pkg::CMD_INSERT && !model.exists(token)
                     && model.num() < `BST_NODE_COUNT) begin
            model[token] = payload;
            exp.status   = 1'b0;
        end
    endtask

    // Token not yet in the model
    function automatic logic [`BST_TOKEN_W-1:0] new_token();
        logic [31:0] r;
        do begin
            r = $random(seed);
        end while (model.exists(r[`BST_TOKEN_W-1:0]));
        return r[`BST_TOKEN_W-1:0];
    endfunction

    function automatic logic [`BST_PAYLOAD_W-1:0] new_payload();
        logic [31:0] r;
        r = $random(seed);
        return r[`BST_PAYLOAD_W-1:0];
    endfunction

    // ------------------------------------------------------------
    // Host side of the two ports
    // ------------------------------------------------------------
    task automatic send_cmd(input logic [7:0] code, input logic [`BST_TOKEN_W-1:0] token,
                            input logic [`BST_PAYLOAD_W-1:0] payload);
        @(posedge aclk);
        #2;
        cmd.cmd     = bst_pkg::cmd_t'(code);
        cmd.token   = token;
        cmd.payload = payload;
        cmd_req     = 1'b1;
        do @(posedge aclk); while (!cmd_ack);
        #2;
        cmd_req = 1'b0;
        do @(posedge aclk); while (cmd_ack);
    endtask

    task automatic get_cpl(input int delay, output bst_pkg::bst_cpl_t got);
        do @(posedge aclk); while (!cpl_req);
        got = cpl;
        repeat (delay) @(posedge aclk);
        #2;
        cpl_ack = 1'b1;
        do @(posedge aclk); while (cpl_req);
        #2;
        cpl_ack = 1'b0;
    endtask

    task automatic check_cpl(input bst_pkg::bst_cpl_t exp, input bst_pkg::bst_cpl_t got,
                             input logic [`BST_TOKEN_W-1:0] token);
        logic ok;
        ok = 1'b1;
        if (got.payload !== exp.payload) begin
            $display("Error cpl.payload token %h: expected %h, got %h",
                     token, exp.payload, got.payload);
            ok = 1'b0;
        end
        if (got.status !== exp.status) begin
            $display("Error cpl.status token %h: expected %h, got %h",
                     token, exp.status, got.status);
            ok = 1'b0;
        end
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
    endtask

    task automatic run_cmd(input logic [7:0] code, input logic [`BST_TOKEN_W-1:0] token,
                           input logic [`BST_PAYLOAD_W-1:0] payload);
        bst_pkg::bst_cpl_t exp;
        bst_pkg::bst_cpl_t got;
        model_step(code, token, payload, exp);
        send_cmd(code, token, payload);
        get_cpl(0, got);
        check_cpl(exp, got, token);
    endtask

    task automatic report_test(input string name, input int fails_before);
        if (fail_count == fails_before) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: %0d check(s) failed", name, fail_count - fails_before);
        end
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic empty_tree_search();
        int f0;
        f0 = fail_count;
        run_cmd(bst_pkg::CMD_SEARCH, new_token(), '0);
        report_test("empty_tree_search", f0);
    endtask

    task automatic insert_then_search();
        int                      f0;
        int                      i;
        int                      j;
        logic [`BST_TOKEN_W-1:0] t;
        logic [`BST_TOKEN_W-1:0] keys [$];
        f0 = fail_count;
        repeat (10) begin
            t = new_token();
            keys.push_back(t);
            run_cmd(bst_pkg::CMD_INSERT, t, new_payload());
        end
        // Shuffle the search order
        for (i = keys.size() - 1; i > 0; i--) begin
            j       = $unsigned($random(seed)) % (i + 1);
            t       = keys[i];
            keys[i] = keys[j];
            keys[j] = t;
        end
        foreach (keys[k]) begin
            run_cmd(bst_pkg::CMD_SEARCH, keys[k], '0);
        end
        run_cmd(bst_pkg::CMD_SEARCH, new_token(), '0);
        report_test("insert_then_search", f0);
    endtask

    task automatic duplicate_insert();
        int                      f0;
        logic [`BST_TOKEN_W-1:0] t;
        f0 = fail_count;
        void'(model.first(t));
        run_cmd(bst_pkg::CMD_INSERT, t, new_payload());
        run_cmd(bst_pkg::CMD_SEARCH, t, '0);
        report_test("duplicate_insert", f0);
    endtask

    task automatic fill_to_capacity();
        int f0;
        f0 = fail_count;
        while (model.num() < `BST_NODE_COUNT) begin
            run_cmd(bst_pkg::CMD_INSERT, new_token(), new_payload());
        end
        // One past capacity
        run_cmd(bst_pkg::CMD_INSERT, new_token(), new_payload());
        foreach (model[k]) begin
            run_cmd(bst_pkg::CMD_SEARCH, k, '0);
        end
        report_test("fill_to_capacity", f0);
    endtask

    task automatic unknown_command();
        int                      f0;
        logic [`BST_TOKEN_W-1:0] t;
        logic [`BST_TOKEN_W-1:0] k;
        f0 = fail_count;
        t  = new_token();
        run_cmd(8'h07, t, new_payload());
        run_cmd(bst_pkg::CMD_SEARCH, t, '0);
        void'(model.first(k));
        run_cmd(bst_pkg::CMD_SEARCH, k, '0);
        report_test("unknown_command", f0);
    endtask

    task automatic completion_backpressure();
        int                      f0;
        logic [`BST_TOKEN_W-1:0] k;
        logic [`BST_TOKEN_W-1:0] toks [3];
        bst_pkg::bst_cpl_t       exp [3];
        bst_pkg::bst_cpl_t       got;
        f0 = fail_count;
        void'(model.first(k));
        toks[0] = k;
        toks[1] = new_token();
        void'(model.last(k));
        toks[2] = k;
        foreach (toks[i]) begin
            model_step(bst_pkg::CMD_SEARCH, toks[i], '0, exp[i]);
        end
        fork
            begin
                foreach (toks[i]) begin
                    send_cmd(bst_pkg::CMD_SEARCH, toks[i], '0);
                end
            end
            begin
                foreach (exp[i]) begin
                    get_cpl(15, got);
                    check_cpl(exp[i], got, toks[i]);
                end
            end
        join
        report_test("completion_backpressure", f0);
    endtask

    initial begin
        aresetn    = 1'b0;
        cmd_req    = 1'b0;
        cmd        = '0;
        cpl_ack    = 1'b0;
        pass_count = 0;
        fail_count = 0;
        repeat (RESET_CYCLES) @(posedge aclk);
        #2;
        aresetn = 1'b1;

        empty_tree_search();
        insert_then_search();
        duplicate_insert();
        // Tree not yet full, so a stray insert would show
        unknown_command();
        fill_to_capacity();
        completion_backpressure();

        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== bst_engine.f ====
+incdir+design
design/bst_pkg.sv
design/cmd_intake.sv
design/tree_walker.sv
design/node_ram.sv
design/cpl_return.sv
design/bst_engine.sv
bench/bst_engine_chk.sv
bench/bst_engine_tb.sv

// ==== design/bst_engine.sv ====
/*
 * BST engine top. One command in flight per stage, completions in order.
 */
`timescale 1ns/1ps

module bst_engine (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              cmd_req,
    output logic              cmd_ack,
    input  bst_pkg::bst_req_t cmd,
    output logic              cpl_req,
    input  logic              cpl_ack,
    output bst_pkg::bst_cpl_t cpl
);

    logic                req_valid;
    logic                req_ready;
    bst_pkg::bst_req_t   req;
    logic                res_valid;
    logic                res_ready;
    bst_pkg::bst_cpl_t   res;
    logic                rd_en;
    bst_pkg::node_addr_t rd_addr;
    bst_pkg::tree_node_t rd_node;
    logic                wr_en;
    bst_pkg::node_addr_t wr_addr;
    bst_pkg::tree_node_t wr_node;

    // ------------------------------------------------------------
    // Command in, tree walk, completion out
    // ------------------------------------------------------------
    cmd_intake cmd_intake_i (
        .aclk, .aresetn, .cmd_req, .cmd_ack, .cmd, .req_valid, .req_ready, .req
    );

    tree_walker tree_walker_i (
        .aclk, .aresetn, .req_valid, .req_ready, .req, .res_valid, .res_ready, .res,
        .rd_en, .rd_addr, .rd_node, .wr_en, .wr_addr, .wr_node
    );

    node_ram node_ram_i (
        .aclk, .rd_en, .rd_addr, .rd_node, .wr_en, .wr_addr, .wr_node
    );

    cpl_return cpl_return_i (
        .aclk, .aresetn, .res_valid, .res_ready, .res, .cpl_req, .cpl_ack, .cpl
    );

endmodule

// ==== design/bst_params.svh ====
/*
 * Widths and tree capacity for the BST engine. BST_NODE_COUNT must equal
 * 2**BST_ADDR_W, because the node count wraps exactly at that depth.
 */
`ifndef BST_PARAMS_SVH
`define BST_PARAMS_SVH

// Token and payload of one entry
`define BST_TOKEN_W 8
`define BST_PAYLOAD_W 32

// Node addressing
`define BST_ADDR_W 5
`define BST_NODE_COUNT 32

`endif

// ==== design/bst_pkg.sv ====
/*
 * Shared types of the BST engine. A cmd value outside the enum is legal on
 * the port and is answered with a failed completion.
 */
package bst_pkg;

`include "bst_params.svh"

    typedef enum logic [7:0] {
        CMD_INSERT = 8'd1,
        CMD_SEARCH = 8'd2
    } cmd_t;

    typedef logic [`BST_ADDR_W-1:0] node_addr_t;

    typedef struct packed {
        cmd_t                     cmd;
        logic [`BST_TOKEN_W-1:0]  token;
        logic [`BST_PAYLOAD_W-1:0] payload;
    } bst_req_t;

    // Status 0 is success, 1 is failure
    typedef struct packed {
        logic [`BST_PAYLOAD_W-1:0] payload;
        logic                      status;
    } bst_cpl_t;

    typedef struct packed {
        logic [`BST_TOKEN_W-1:0]   token;
        logic [`BST_PAYLOAD_W-1:0] payload;
        node_addr_t                left;
        logic                      left_valid;
        node_addr_t                right;
        logic                      right_valid;
    } tree_node_t;

endpackage

// ==== design/cmd_intake.sv ====
/*
 * Four-phase command receiver. cmd must stay stable while cmd_req is high,
 * and one command is held while the walker is busy.
 */
`timescale 1ns/1ps

module cmd_intake (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              cmd_req,
    output logic              cmd_ack,
    input  bst_pkg::bst_req_t cmd,
    output logic              req_valid,
    input  logic              req_ready,
    output bst_pkg::bst_req_t req
);

    // Acknowledged means waiting for cmd_req to fall
    typedef enum logic {
        PH_IDLE,
        PH_ACK
    } phase_t;

    phase_t            phase;
    logic              full;
    logic              capture;
    bst_pkg::bst_req_t req_q;

    assign capture = (phase == PH_IDLE) && cmd_req && !full;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            phase <= PH_IDLE;
            full  <= 1'b0;
        end else begin
            if (capture) begin
                phase <= PH_ACK;
            end else if (phase == PH_ACK && !cmd_req) begin
                phase <= PH_IDLE;
            end
            if (capture) begin
                full <= 1'b1;
            end else if (req_valid && req_ready) begin
                full <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (capture) begin
            req_q <= cmd;
        end
    end

    assign cmd_ack   = (phase == PH_ACK);
    assign req_valid = full;
    assign req       = req_q;

endmodule

// ==== design/cpl_return.sv ====
/*
 * Four-phase completion sender. cpl is held while cpl_req is high, and the
 * next result is taken only once the host has dropped cpl_ack.
 */
`timescale 1ns/1ps

module cpl_return (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              res_valid,
    output logic              res_ready,
    input  bst_pkg::bst_cpl_t res,
    output logic              cpl_req,
    input  logic              cpl_ack,
    output bst_pkg::bst_cpl_t cpl
);

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_REQ,
        PH_DROP
    } phase_t;

    phase_t            phase;
    bst_pkg::bst_cpl_t cpl_q;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            phase <= PH_IDLE;
        end else begin
            case (phase)
                PH_IDLE: if (res_valid) phase <= PH_REQ;
                PH_REQ:  if (cpl_ack) phase <= PH_DROP;
                // Wait for the host to release cpl_ack
                PH_DROP: if (!cpl_ack) phase <= PH_IDLE;
                default: phase <= PH_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (res_valid && res_ready) begin
            cpl_q <= res;
        end
    end

    assign res_ready = (phase == PH_IDLE);
    assign cpl_req   = (phase == PH_REQ);
    assign cpl       = cpl_q;

endmodule

// ==== design/node_ram.sv ====
/*
 * Node memory, one read and one write port. Contents are undefined after
 * reset and a read returns data one cycle after rd_en.
 */
`timescale 1ns/1ps

`include "bst_params.svh"

module node_ram (
    input  logic                aclk,
    input  logic                rd_en,
    input  bst_pkg::node_addr_t rd_addr,
    output bst_pkg::tree_node_t rd_node,
    input  logic                wr_en,
    input  bst_pkg::node_addr_t wr_addr,
    input  bst_pkg::tree_node_t wr_node
);

    bst_pkg::tree_node_t mem [`BST_NODE_COUNT];

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_node;
        end
    end

    // Output holds the last node read
    always_ff @(posedge aclk) begin
        if (rd_en) begin
            rd_node <= mem[rd_addr];
        end
    end

endmodule

// ==== design/tree_walker.sv ====
/*
 * One FSM walks the tree for search and insert. Nodes are never freed, so
 * the node count doubles as the next free address and the root sits at 0.
 */
`timescale 1ns/1ps

`include "bst_params.svh"

module tree_walker (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  bst_pkg::bst_req_t     req,
    output logic                  res_valid,
    input  logic                  res_ready,
    output bst_pkg::bst_cpl_t     res,
    output logic                  rd_en,
    output bst_pkg::node_addr_t   rd_addr,
    input  bst_pkg::tree_node_t   rd_node,
    output logic                  wr_en,
    output bst_pkg::node_addr_t   wr_addr,
    output bst_pkg::tree_node_t   wr_node
);

    localparam logic [`BST_ADDR_W:0] NODE_MAX = (`BST_ADDR_W+1)'(`BST_NODE_COUNT);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_COMPARE,
        ST_WRITE_NODE,
        ST_LINK_PARENT,
        ST_RESULT
    } state_t;

    state_t               state;
    logic [`BST_ADDR_W:0] count_q;
    bst_pkg::bst_req_t    cur_q;
    bst_pkg::tree_node_t  parent_q;
    bst_pkg::node_addr_t  addr_q;
    bst_pkg::bst_cpl_t    res_q;
    bst_pkg::node_addr_t  new_addr;
    logic                 req_known;
    logic                 cur_insert;
    logic                 tok_eq;
    logic                 go_left;
    logic                 child_valid;
    bst_pkg::node_addr_t  child_addr;

    assign req_known  = (req.cmd == bst_pkg::CMD_INSERT) || (req.cmd == bst_pkg::CMD_SEARCH);
    assign cur_insert = (cur_q.cmd == bst_pkg::CMD_INSERT);
    assign new_addr   = count_q[`BST_ADDR_W-1:0];

    // Descent decision on the node returned by the RAM
    assign tok_eq      = (cur_q.token == rd_node.token);
    assign go_left     = (cur_q.token < rd_node.token);
    assign child_valid = go_left ? rd_node.left_valid : rd_node.right_valid;
    assign child_addr  = go_left ? rd_node.left : rd_node.right;

    // ------------------------------------------------------------
    // Control
    // ------------------------------------------------------------
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state   <= ST_IDLE;
            count_q <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_valid) begin
                        if (!req_known) begin
                            state <= ST_RESULT;
                        end else if (count_q == '0) begin
                            // Empty tree, insert goes straight to the root
                            state <= (req.cmd == bst_pkg::CMD_INSERT) ? ST_WRITE_NODE
                                                                       : ST_RESULT;
                        end else begin
                            state <= ST_READ;
                        end
                    end
                end
                ST_READ: state <= ST_COMPARE;
                ST_COMPARE: begin
                    if (tok_eq) begin
                        state <= ST_RESULT;
                    end else if (child_valid) begin
                        state <= ST_READ;
                    end else if (cur_insert && count_q != NODE_MAX) begin
                        state <= ST_WRITE_NODE;
                    end else begin
                        state <= ST_RESULT;
                    end
                end
                ST_WRITE_NODE: begin
                    if (count_q == '0) begin
                        count_q <= count_q + 1'b1;
                        state   <= ST_RESULT;
                    end else begin
                        state <= ST_LINK_PARENT;
                    end
                end
                ST_LINK_PARENT: begin
                    count_q <= count_q + 1'b1;
                    state   <= ST_RESULT;
                end
                ST_RESULT: begin
                    if (res_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------
    always_ff @(posedge aclk) begin
        case (state)
            ST_IDLE: begin
                if (req_valid) begin
                    cur_q         <= req;
                    addr_q        <= '0;
                    // Failure unless a later state says otherwise
                    res_q.payload <= '0;
                    res_q.status  <= 1'b1;
                end
            end
            ST_COMPARE: begin
                if (tok_eq) begin
                    res_q.payload <= cur_insert ? '0 : rd_node.payload;
                    res_q.status  <= cur_insert;
                end else if (child_valid) begin
                    addr_q <= child_addr;
                end else begin
                    parent_q <= rd_node;
                end
            end
            ST_WRITE_NODE: begin
                res_q.payload <= '0;
                res_q.status  <= 1'b0;
            end
            default: ;
        endcase
    end

    // Memory requests decoded from the state
    always_comb begin
        wr_node = parent_q;
        if (state == ST_WRITE_NODE) begin
            wr_node         = '0;
            wr_node.token   = cur_q.token;
            wr_node.payload = cur_q.payload;
        end else if (cur_q.token < parent_q.token) begin
            wr_node.left       = new_addr;
            wr_node.left_valid = 1'b1;
        end else begin
            wr_node.right       = new_addr;
            wr_node.right_valid = 1'b1;
        end
    end

    assign rd_en     = (state == ST_READ);
    assign rd_addr   = addr_q;
    assign wr_en     = (state == ST_WRITE_NODE) || (state == ST_LINK_PARENT);
    assign wr_addr   = (state == ST_LINK_PARENT) ? addr_q : new_addr;
    assign req_ready = (state == ST_IDLE);
    assign res_valid = (state == ST_RESULT);
    assign res       = res_q;

endmodule
